// File: source/led_matrix_cfg.svh
/* panel geometry, brightness plane count and scan timing macros */
`ifndef LED_MATRIX_CFG_SVH
`define LED_MATRIX_CFG_SVH

// panel geometry
`define LM_PANEL_WIDTH 16        // columns per row
`define LM_PANEL_HALF_HEIGHT 4   // row pairs, full height is twice this

// one plane per bit of a colour channel
`define LM_PLANE_COUNT 4

// scan timing
`define LM_TICK_DIV 2            // clk_root cycles per scan tick
`define LM_OE_BASE 4             // display ticks of plane 0, doubled per plane

`endif

// File: source/matrix_pkg.sv
/* panel, frame-buffer address and pixel vector types */
`include "led_matrix_cfg.svh"

package matrix_pkg;

    // panel addressing
    typedef logic [$clog2(`LM_PANEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(`LM_PANEL_HALF_HEIGHT)-1:0] row_addr_t;  // row pair on the pins

    // full-height row on top, column below
    typedef logic [$clog2(`LM_PANEL_HALF_HEIGHT * 2) + $clog2(`LM_PANEL_WIDTH)-1:0] fb_addr_t;

    // pixel data
    typedef logic [`LM_PLANE_COUNT-1:0] channel_t;
    typedef logic [3*`LM_PLANE_COUNT-1:0] pixel_t;     // red, green, blue from the top
    typedef logic [2:0] rgb_bits_t;                    // red in bit 0

    // brightness planes
    typedef logic [$clog2(`LM_PLANE_COUNT)-1:0] plane_t;
    typedef logic [`LM_PLANE_COUNT-1:0] plane_mask_t;

endpackage

// File: source/command_pkg.sv
/* command stream byte and opcode types */

package command_pkg;

    typedef logic [7:0] cmd_byte_t;

    // first byte of every command
    typedef enum cmd_byte_t {
        OP_WRITE_PIXEL      = 8'h50,  // addr, high, low
        OP_SET_RGB_ENABLE   = 8'h43,  // one mask byte
        OP_SET_PLANE_ENABLE = 8'h42   // one mask byte
    } opcode_t;

endpackage

// File: source/command_decoder.sv
/* command byte parser: pixel assembly, frame-buffer write strobe
   and the colour / plane enable registers */
`timescale 1ns/10ps

module command_decoder (
    input  logic                    clk_root,
    input  logic                    arst_n,
    input  command_pkg::cmd_byte_t  in_byte,
    input  logic                    in_valid,
    output logic                    in_ready,
    output logic                    wr_en,
    output matrix_pkg::fb_addr_t    wr_addr,
    output matrix_pkg::pixel_t      wr_data,
    output matrix_pkg::rgb_bits_t   rgb_enable,
    output matrix_pkg::plane_mask_t plane_enable
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_HIGH,
        ST_LOW,
        ST_COMMIT,
        ST_ENABLE
    } dec_state_t;

    dec_state_t state;
    logic       rgb_sel;    // enable payload targets the colour mask
    logic       take;

    assign in_ready = (state != ST_COMMIT);   // only stall is the write cycle
    assign wr_en    = (state == ST_COMMIT);
    assign take     = in_valid && in_ready;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state        <= ST_IDLE;
            rgb_sel      <= 1'b0;
            rgb_enable   <= '1;
            plane_enable <= '1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        case (in_byte)
                            command_pkg::OP_WRITE_PIXEL: state <= ST_ADDR;
                            command_pkg::OP_SET_RGB_ENABLE: begin
                                rgb_sel <= 1'b1;
                                state   <= ST_ENABLE;
                            end
                            command_pkg::OP_SET_PLANE_ENABLE: begin
                                rgb_sel <= 1'b0;
                                state   <= ST_ENABLE;
                            end
                            default: state <= ST_IDLE;  // unknown, dropped
                        endcase
                    end
                end
                ST_ADDR: if (take) state <= ST_HIGH;
                ST_HIGH: if (take) state <= ST_LOW;
                ST_LOW: if (take) state <= ST_COMMIT;
                ST_COMMIT: state <= ST_IDLE;
                ST_ENABLE: begin
                    if (take) begin
                        if (rgb_sel) begin
                            rgb_enable <= in_byte[2:0];
                        end else begin
                            plane_enable <= in_byte[3:0];
                        end
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // pixel assembly
    always_ff @(posedge clk_root) begin
        if (take) begin
            case (state)
                ST_ADDR: wr_addr <= in_byte[6:0];        // bit 7 ignored
                ST_HIGH: wr_data[11:8] <= in_byte[3:0];  // red
                ST_LOW: wr_data[7:0] <= in_byte;         // green, blue
                default: ;
            endcase
        end
    end

    // write cycle blocks input
    write_stalls_input: assert property (@(posedge clk_root) disable iff (!arst_n)
        wr_en |-> !in_ready);

endmodule

// File: source/pixel_ram.sv
/* frame buffer, one write port and one registered read port */
`timescale 1ns/10ps
`include "led_matrix_cfg.svh"

module pixel_ram (
    input  logic                 clk_root,
    input  logic                 wr_en,
    input  matrix_pkg::fb_addr_t wr_addr,
    input  matrix_pkg::pixel_t   wr_data,
    input  matrix_pkg::fb_addr_t rd_addr,
    output matrix_pkg::pixel_t   rd_data
);

    localparam int DEPTH = `LM_PANEL_WIDTH * `LM_PANEL_HALF_HEIGHT * 2;

    matrix_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk_root) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read before write on a collision
    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/framebuffer_fetch.sv
/* fetch sequencer: reads the top and bottom pixel of a column,
   picks the plane bit per channel and applies the enable masks */
`timescale 1ns/10ps
`include "led_matrix_cfg.svh"

module framebuffer_fetch (
    input  logic                    clk_root,
    input  logic                    arst_n,
    input  logic                    fetch_req,
    input  matrix_pkg::col_addr_t   fetch_col,
    input  matrix_pkg::row_addr_t   fetch_row,
    input  matrix_pkg::plane_t      fetch_plane,
    input  matrix_pkg::rgb_bits_t   rgb_enable,
    input  matrix_pkg::plane_mask_t plane_enable,
    input  matrix_pkg::pixel_t      rd_data,
    output matrix_pkg::fb_addr_t    rd_addr,
    output logic                    fetch_valid,
    output matrix_pkg::rgb_bits_t   rgb_top,
    output matrix_pkg::rgb_bits_t   rgb_bottom
);

    localparam int ROW_W = $bits(matrix_pkg::fb_addr_t) - $bits(matrix_pkg::col_addr_t);

    typedef enum logic [2:0] {F_IDLE, F_TOP, F_BOT, F_LAST, F_VALID} fetch_state_t;

    fetch_state_t          state;
    logic [ROW_W-1:0]      top_row;
    logic [ROW_W-1:0]      bottom_row;
    matrix_pkg::rgb_bits_t gated;

    function automatic matrix_pkg::rgb_bits_t plane_bits(
        input matrix_pkg::pixel_t px,
        input matrix_pkg::plane_t plane
    );
        matrix_pkg::channel_t red;
        matrix_pkg::channel_t green;
        matrix_pkg::channel_t blue;
        red   = px[11:8];
        green = px[7:4];
        blue  = px[3:0];
        return {blue[plane], green[plane], red[plane]};
    endfunction

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state <= F_IDLE;
        end else begin
            case (state)
                F_IDLE: if (fetch_req) state <= F_TOP;
                F_TOP: state <= F_BOT;
                F_BOT: state <= F_LAST;
                F_LAST: state <= F_VALID;
                default: state <= F_IDLE;   // request drops after the pulse
            endcase
        end
    end

    assign top_row     = ROW_W'(fetch_row);
    assign bottom_row  = top_row + ROW_W'(`LM_PANEL_HALF_HEIGHT);
    assign rd_addr     = (state == F_BOT) ? {bottom_row, fetch_col} : {top_row, fetch_col};
    assign fetch_valid = (state == F_VALID);

    assign gated = plane_bits(rd_data, fetch_plane) & rgb_enable
                 & {3{plane_enable[fetch_plane]}};

    always_ff @(posedge clk_root) begin
        if (state == F_BOT) begin
            rgb_top <= gated;      // top pixel on rd_data
        end
        if (state == F_LAST) begin
            rgb_bottom <= gated;
        end
    end

    // scanner keeps its request steady until served
    req_held: assert property (@(posedge clk_root) disable iff (!arst_n)
        (fetch_req && !fetch_valid) |=> (fetch_req && $stable(fetch_col)
            && $stable(fetch_row) && $stable(fetch_plane)));

endmodule

// File: source/matrix_scan.sv
/* panel scanner: tick divider, per-column fetch and shift,
   row latch and plane-weighted output enable */
`timescale 1ns/10ps
`include "led_matrix_cfg.svh"

module matrix_scan (
    input  logic                  clk_root,
    input  logic                  arst_n,
    input  logic                  fetch_valid,
    input  matrix_pkg::rgb_bits_t rgb_top_in,
    input  matrix_pkg::rgb_bits_t rgb_bottom_in,
    output logic                  fetch_req,
    output matrix_pkg::col_addr_t fetch_col,
    output matrix_pkg::row_addr_t fetch_row,
    output matrix_pkg::plane_t    fetch_plane,
    output matrix_pkg::rgb_bits_t rgb_top,
    output matrix_pkg::rgb_bits_t rgb_bottom,
    output logic                  clk_pixel,
    output logic                  row_latch,
    output logic                  oe_n,
    output matrix_pkg::row_addr_t row_addr
);

    localparam int TICK_W = $clog2(`LM_TICK_DIV + 1);
    localparam int DISP_W = $clog2(`LM_OE_BASE << `LM_PLANE_COUNT);

    typedef enum logic [2:0] {S_FETCH, S_SETUP, S_SHIFT, S_LATCH, S_DISPLAY} scan_state_t;

    scan_state_t           state;
    logic [TICK_W-1:0]     tick_cnt;
    logic                  tick;
    matrix_pkg::col_addr_t col_cnt;
    matrix_pkg::row_addr_t row_cnt;
    matrix_pkg::plane_t    plane_cnt;
    logic [DISP_W-1:0]     disp_cnt;    // display ticks left, minus one

    // tick divider, parked while a fetch is outstanding
    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
        end else if (state == S_FETCH || tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = (state != S_FETCH) && (tick_cnt == TICK_W'(`LM_TICK_DIV - 1));

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            state     <= S_FETCH;
            col_cnt   <= '0;
            row_cnt   <= '0;
            plane_cnt <= '0;
            disp_cnt  <= '0;
            row_addr  <= '0;
        end else begin
            case (state)
                S_FETCH: if (fetch_valid) state <= S_SETUP;
                S_SETUP: if (tick) state <= S_SHIFT;
                S_SHIFT: begin
                    if (tick) begin
                        if (col_cnt == matrix_pkg::col_addr_t'(`LM_PANEL_WIDTH - 1)) begin
                            col_cnt  <= '0;
                            row_addr <= row_cnt;    // new row goes out with the latch
                            state    <= S_LATCH;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                            state   <= S_FETCH;
                        end
                    end
                end
                S_LATCH: begin
                    if (tick) begin
                        disp_cnt <= DISP_W'((`LM_OE_BASE << plane_cnt) - 1);
                        state    <= S_DISPLAY;
                    end
                end
                S_DISPLAY: begin
                    if (tick) begin
                        if (disp_cnt == '0) begin
                            state <= S_FETCH;
                            if (plane_cnt == matrix_pkg::plane_t'(`LM_PLANE_COUNT - 1)) begin
                                plane_cnt <= '0;
                                if (row_cnt == matrix_pkg::row_addr_t'(`LM_PANEL_HALF_HEIGHT - 1)) begin
                                    row_cnt <= '0;
                                end else begin
                                    row_cnt <= row_cnt + 1'b1;
                                end
                            end else begin
                                plane_cnt <= plane_cnt + 1'b1;
                            end
                        end else begin
                            disp_cnt <= disp_cnt - 1'b1;
                        end
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // column data onto the pins
    always_ff @(posedge clk_root) begin
        if (state == S_FETCH && fetch_valid) begin
            rgb_top    <= rgb_top_in;
            rgb_bottom <= rgb_bottom_in;
        end
    end

    assign fetch_req   = (state == S_FETCH);
    assign fetch_col   = col_cnt;
    assign fetch_row   = row_cnt;
    assign fetch_plane = plane_cnt;
    assign clk_pixel   = (state == S_SHIFT);
    assign row_latch   = (state == S_LATCH);
    assign oe_n        = (state != S_DISPLAY);  // dark while shifting and latching

    latch_blanked: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |-> oe_n);

endmodule

// File: source/led_matrix_top.sv
/* top level: command decoder, frame buffer, fetch unit and scanner */
`timescale 1ns/10ps

module led_matrix_top (
    input  logic                   clk_root,
    input  logic                   arst_n,
    input  command_pkg::cmd_byte_t in_byte,
    input  logic                   in_valid,
    output logic                   in_ready,
    output matrix_pkg::rgb_bits_t  rgb_top,
    output matrix_pkg::rgb_bits_t  rgb_bottom,
    output logic                   clk_pixel,
    output logic                   row_latch,
    output logic                   oe_n,
    output matrix_pkg::row_addr_t  row_addr
);

    // write side
    logic                    wr_en;
    matrix_pkg::fb_addr_t    wr_addr;
    matrix_pkg::pixel_t      wr_data;
    matrix_pkg::rgb_bits_t   rgb_enable;
    matrix_pkg::plane_mask_t plane_enable;

    // read side
    matrix_pkg::fb_addr_t    rd_addr;
    matrix_pkg::pixel_t      rd_data;
    logic                    fetch_req;
    logic                    fetch_valid;
    matrix_pkg::col_addr_t   fetch_col;
    matrix_pkg::row_addr_t   fetch_row;
    matrix_pkg::plane_t      fetch_plane;
    matrix_pkg::rgb_bits_t   fetch_top;
    matrix_pkg::rgb_bits_t   fetch_bottom;

    command_decoder u_decoder (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .in_byte      (in_byte),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable)
    );

    pixel_ram u_ram (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    framebuffer_fetch u_fetch (
        .clk_root     (clk_root),
        .arst_n       (arst_n),
        .fetch_req    (fetch_req),
        .fetch_col    (fetch_col),
        .fetch_row    (fetch_row),
        .fetch_plane  (fetch_plane),
        .rgb_enable   (rgb_enable),
        .plane_enable (plane_enable),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .fetch_valid  (fetch_valid),
        .rgb_top      (fetch_top),
        .rgb_bottom   (fetch_bottom)
    );

    matrix_scan u_scan (
        .clk_root      (clk_root),
        .arst_n        (arst_n),
        .fetch_valid   (fetch_valid),
        .rgb_top_in    (fetch_top),
        .rgb_bottom_in (fetch_bottom),
        .fetch_req     (fetch_req),
        .fetch_col     (fetch_col),
        .fetch_row     (fetch_row),
        .fetch_plane   (fetch_plane),
        .rgb_top       (rgb_top),
        .rgb_bottom    (rgb_bottom),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .oe_n          (oe_n),
        .row_addr      (row_addr)
    );

endmodule

// File: sim/led_matrix_tb.sv
/* testbench for the LED matrix driver: clock, reset, random command stream,
   frame-buffer model, per-latch frame and output-enable checks, watchdog */
`timescale 1ns/10ps
`include "led_matrix_cfg.svh"

module led_matrix_tb;

    localparam int CLK_PERIOD     = 40;
    localparam int FETCH_CYCLES   = 8;                      // allowance per column fetch
    localparam int FRAME_CHECKS   = 7;
    localparam int FRAMES_PLANNED = FRAME_CHECKS * 2 + 4;   // alignment plus frame, per check
    localparam int FB_DEPTH       = `LM_PANEL_WIDTH * `LM_PANEL_HALF_HEIGHT * 2;
    localparam int FRAME_LATCHES  = `LM_PANEL_HALF_HEIGHT * `LM_PLANE_COUNT;

    logic                   clk_root;
    logic                   arst_n;
    command_pkg::cmd_byte_t in_byte;
    logic                   in_valid;
    logic                   in_ready;
    matrix_pkg::rgb_bits_t  rgb_top;
    matrix_pkg::rgb_bits_t  rgb_bottom;
    logic                   clk_pixel;
    logic                   row_latch;
    logic                   oe_n;
    matrix_pkg::row_addr_t  row_addr;

    // model of the frame buffer and the enables
    matrix_pkg::pixel_t      model_fb [FB_DEPTH];
    matrix_pkg::rgb_bits_t   model_rgb;
    matrix_pkg::plane_mask_t model_plane;
    int                      parse_state;   // 0 opcode, 1-3 pixel bytes, 4 rgb, 5 plane
    matrix_pkg::fb_addr_t    parse_addr;
    matrix_pkg::channel_t    parse_red;

    // panel observation
    matrix_pkg::rgb_bits_t top_buf [`LM_PANEL_WIDTH];
    matrix_pkg::rgb_bits_t bot_buf [`LM_PANEL_WIDTH];
    int   col_idx;
    int   latch_count;
    int   oe_cnt;
    int   oe_latch;      // latch that opened the current display window
    int   oe_checked;
    int   chk_lo;
    bit   frame_armed;
    bit   oe_checks_on;
    logic prev_clk_pixel;
    logic prev_row_latch;
    logic prev_oe_n;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    int stalls;

    led_matrix_top uut (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .in_byte    (in_byte),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n),
        .row_addr   (row_addr)
    );

    initial begin
        clk_root = 1'b0;
        forever #(CLK_PERIOD / 2) clk_root = ~clk_root;
    end

    task automatic check_rgb(input string name, input matrix_pkg::rgb_bits_t got,
                             input matrix_pkg::rgb_bits_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_row(input string name, input matrix_pkg::row_addr_t got,
                             input matrix_pkg::row_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // cycles for one full frame, scan every row pair through every plane
    function automatic int frame_cycles();
        int cyc;
        cyc = 0;
        for (int p = 0; p < `LM_PLANE_COUNT; p++) begin
            cyc += `LM_PANEL_WIDTH * (FETCH_CYCLES + 2 * `LM_TICK_DIV) + `LM_TICK_DIV
                 + (`LM_OE_BASE << p) * `LM_TICK_DIV;
        end
        return cyc * `LM_PANEL_HALF_HEIGHT;
    endfunction

    function automatic command_pkg::cmd_byte_t rand_byte();
        return command_pkg::cmd_byte_t'($urandom);
    endfunction

    // plane bit of each channel, red in bit 0, then the masks
    function automatic matrix_pkg::rgb_bits_t model_bits(input matrix_pkg::pixel_t px,
                                                         input int plane);
        matrix_pkg::rgb_bits_t b;
        b[0] = px[8 + plane];
        b[1] = px[4 + plane];
        b[2] = px[plane];
        return b & model_rgb & {3{model_plane[plane]}};
    endfunction

    function automatic bit in_window(input int idx);
        return frame_armed && idx >= chk_lo && idx < chk_lo + FRAME_LATCHES;
    endfunction

    task automatic model_byte(input command_pkg::cmd_byte_t b);
        case (parse_state)
            0: begin
                if (b == command_pkg::OP_WRITE_PIXEL) parse_state = 1;
                else if (b == command_pkg::OP_SET_RGB_ENABLE) parse_state = 4;
                else if (b == command_pkg::OP_SET_PLANE_ENABLE) parse_state = 5;
            end
            1: begin
                parse_addr  = b[6:0];
                parse_state = 2;
            end
            2: begin
                parse_red   = b[3:0];
                parse_state = 3;
            end
            3: begin
                model_fb[parse_addr] = {parse_red, b};
                parse_state = 0;
            end
            4: begin
                model_rgb   = b[2:0];
                parse_state = 0;
            end
            default: begin
                model_plane = b[3:0];
                parse_state = 0;
            end
        endcase
    endtask

    // called at a falling edge, returns at the falling edge after the transfer
    task automatic send_byte(input command_pkg::cmd_byte_t b);
        in_byte  = b;
        in_valid = 1'b1;
        while (!in_ready) begin
            stalls++;
            @(negedge clk_root);
        end
        @(negedge clk_root);
        model_byte(b);
    endtask

    task automatic hold_idle(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk_root);
    endtask

    task automatic send_random_cmd();
        int                     nbytes;
        command_pkg::cmd_byte_t op;
        case ($urandom % 4)
            0: begin
                op     = command_pkg::OP_WRITE_PIXEL;
                nbytes = 3;
            end
            1: begin
                op     = command_pkg::OP_SET_RGB_ENABLE;
                nbytes = 1;
            end
            2: begin
                op     = command_pkg::OP_SET_PLANE_ENABLE;
                nbytes = 1;
            end
            default: begin
                op = rand_byte();
                while (op == command_pkg::OP_WRITE_PIXEL || op == command_pkg::OP_SET_RGB_ENABLE
                       || op == command_pkg::OP_SET_PLANE_ENABLE) begin
                    op = rand_byte();
                end
                nbytes = 0;   // unknown opcode stands alone
            end
        endcase
        send_byte(op);
        for (int i = 0; i < nbytes; i++) begin
            if ($urandom % 2) hold_idle($urandom % 4);
            send_byte(rand_byte());
        end
    endtask

    task automatic check_latch(input int idx);
        int plane;
        int row;
        plane = idx % `LM_PLANE_COUNT;
        row   = (idx / `LM_PLANE_COUNT) % `LM_PANEL_HALF_HEIGHT;
        check_row($sformatf("row_addr latch %0d", idx), row_addr, matrix_pkg::row_addr_t'(row));
        check_count($sformatf("shifted columns latch %0d", idx), col_idx, `LM_PANEL_WIDTH);
        for (int c = 0; c < `LM_PANEL_WIDTH; c++) begin
            check_rgb($sformatf("rgb_top latch %0d col %0d", idx, c), top_buf[c],
                      model_bits(model_fb[row * `LM_PANEL_WIDTH + c], plane));
            check_rgb($sformatf("rgb_bottom latch %0d col %0d", idx, c), bot_buf[c],
                      model_bits(model_fb[(row + `LM_PANEL_HALF_HEIGHT) * `LM_PANEL_WIDTH + c],
                                 plane));
        end
    endtask

    // first frame whose fetches all start after now
    task automatic check_frame(input bit with_oe);
        chk_lo       = ((latch_count + FRAME_LATCHES) / FRAME_LATCHES) * FRAME_LATCHES;
        oe_checks_on = with_oe;
        frame_armed  = 1'b1;
        wait (latch_count >= chk_lo + FRAME_LATCHES + 1);
        frame_armed  = 1'b0;
        @(negedge clk_root);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    // panel observer, sampled mid-cycle where outputs are settled
    always @(negedge clk_root) begin
        if (arst_n) begin
            if (row_latch && !oe_n) begin
                errors++;
                $display("error: oe_n low while row_latch is high at %0t", $time);
            end
            if (clk_pixel && !prev_clk_pixel) begin
                if (col_idx < `LM_PANEL_WIDTH) begin
                    top_buf[col_idx] = rgb_top;
                    bot_buf[col_idx] = rgb_bottom;
                end
                col_idx++;
            end
            if (!oe_n) oe_cnt++;
            if (oe_n && !prev_oe_n && oe_checks_on && in_window(oe_latch)) begin
                check_count($sformatf("oe_n low cycles latch %0d", oe_latch), oe_cnt,
                            (`LM_OE_BASE << (oe_latch % `LM_PLANE_COUNT)) * `LM_TICK_DIV);
                oe_checked++;
            end
            if (row_latch && !prev_row_latch) begin
                if (in_window(latch_count)) check_latch(latch_count);
                oe_latch = latch_count;
                oe_cnt   = 0;
                col_idx  = 0;
                latch_count++;
            end
        end
        prev_clk_pixel = clk_pixel;
        prev_row_latch = row_latch;
        prev_oe_n      = oe_n;
    end

    initial begin
        longint limit;
        limit = longint'(FRAMES_PLANNED) * frame_cycles() * 2 * CLK_PERIOD;
        #(limit);
        $display("timeout: run went past %0d ns, scan or input handshake stalled", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int err_mark;
        int seed_val;
        int stall_mark;
        seed_val       = $urandom(5);
        arst_n         = 1'b0;
        in_valid       = 1'b0;
        in_byte        = '0;
        model_rgb      = '1;   // enables come out of reset all on
        model_plane    = '1;
        parse_state    = 0;
        col_idx        = 0;
        latch_count    = 0;
        oe_cnt         = 0;
        oe_latch       = -1;
        oe_checked     = 0;
        chk_lo         = 0;
        frame_armed    = 1'b0;
        oe_checks_on   = 1'b0;
        prev_clk_pixel = 1'b0;
        prev_row_latch = 1'b0;
        prev_oe_n      = 1'b1;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        stalls         = 0;

        // 1: outputs while held in reset
        err_mark = errors;
        @(negedge clk_root);
        check_flag("clk_pixel", clk_pixel, 1'b0);
        check_flag("row_latch", row_latch, 1'b0);
        check_flag("oe_n", oe_n, 1'b1);
        check_flag("in_ready", in_ready, 1'b1);
        check_row("row_addr", row_addr, '0);
        @(negedge clk_root);
        arst_n = 1'b1;
        report_test("reset state", err_mark);

        // 2: fill every pixel back to back, write cycles stall the stream
        err_mark   = errors;
        stall_mark = stalls;
        for (int a = 0; a < FB_DEPTH; a++) begin
            send_byte(command_pkg::OP_WRITE_PIXEL);
            send_byte({rand_byte() & 8'h80} | command_pkg::cmd_byte_t'(a));  // bit 7 is noise
            send_byte(rand_byte());
            send_byte(rand_byte());
        end
        hold_idle(1);
        // each commit holds off the following opcode for exactly one cycle
        check_count("in_ready stall cycles during fill", stalls - stall_mark, FB_DEPTH - 1);
        check_frame(1'b0);
        report_test("full buffer frame", err_mark);

        // 3: display windows per plane
        err_mark   = errors;
        oe_checked = 0;
        check_frame(1'b1);
        check_count("display windows checked", oe_checked, FRAME_LATCHES);
        report_test("plane weighted oe_n", err_mark);

        // 4: random masks between frames
        err_mark = errors;
        for (int r = 0; r < 3; r++) begin
            send_byte(command_pkg::OP_SET_RGB_ENABLE);
            send_byte(rand_byte());
            send_byte(command_pkg::OP_SET_PLANE_ENABLE);
            send_byte(rand_byte());
            hold_idle(1);
            check_frame(1'b0);
        end
        report_test("colour and plane masks", err_mark);

        // 5: mixed bursts with gaps in valid
        err_mark = errors;
        for (int r = 0; r < 2; r++) begin
            for (int n = 0; n < 24; n++) begin
                send_random_cmd();
                if ($urandom % 2) hold_idle($urandom % 4);
            end
            hold_idle(1);
            check_frame(1'b1);
        end
        report_test("mixed command bursts", err_mark);

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d stall cycles",
                 tests_run, tests_failed, checks, errors, stalls);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+source
source/matrix_pkg.sv
source/command_pkg.sv
source/command_decoder.sv
source/pixel_ram.sv
source/framebuffer_fetch.sv
source/matrix_scan.sv
source/led_matrix_top.sv
sim/led_matrix_tb.sv

// File: Bender.yml
package:
  name: led_matrix

sources:
  - include_dirs:
      - source
    files:
      - source/matrix_pkg.sv
      - source/command_pkg.sv
      - source/command_decoder.sv
      - source/pixel_ram.sv
      - source/framebuffer_fetch.sv
      - source/matrix_scan.sv
      - source/led_matrix_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - sim/led_matrix_tb.sv
